// ==== verification/sim_chip_trace.txt ====
# kind(0 step, 1 wait for pok) op(0 nop 1 wrout 2 wroe 3 wrdio 4 rdmio 5 rddio) wdata gpio
# pins(b0 uart_rx b1 sck b2 csb b3 sdi) exp_gpio exp_gpio_en exp_pout(b0 tx b1 tx_en b2 sdo b3 sdo_en)
# exp_pok exp_rvalid exp_rdata exp_strap(b1:0 dft b3:2 tap), hex except kind op pok rvalid
0 1 FFFFFFFF 82215A5C 6 00000000 00000000 0 0 0 00000000 0
0 2 FFFFFFFF 82215A5C 6 00000000 00000000 0 0 0 00000000 0
0 4 00000000 82215A5C 6 00000000 00000000 0 0 0 00000000 0
0 3 000000FF 82215A5C 6 00000000 00000000 0 0 0 00000000 0
1 0 00000000 82215A5C 6 00000000 00000000 0 1 0 00000000 0
1 0 00000000 82215A5C 6 00000000 00000000 0 0 0 00000000 0
1 0 00000000 FFFFFFFF F 00000000 00000000 0 1 0 00000000 0
0 0 00000000 FFFFFFFF F 00000000 00000000 0 1 0 00000000 9
0 1 DEADBEEF FFFFFFFF F DAADBEEF 00000000 1 1 0 00000000 9
0 2 0F0FF0F0 FFFFFFFF F DAADBEEF 0B0FF0F0 3 1 0 00000000 9
0 2 12345678 FFFFFFFF F DAADBEEF 12345678 1 1 0 00000000 9
0 3 000000C5 FFFFFFFF F DAADBEEF 12345678 9 1 0 00000000 9
0 3 000000A8 FFFFFFFF F DAADBEEF 12345678 D 1 0 00000000 9
0 4 00000000 7D5EA5C3 D DAADBEEF 12345678 D 1 1 7F5EA5C3 9
0 5 00000000 7D5EA5C3 D DAADBEEF 12345678 D 1 1 00000006 9
0 0 00000000 7D5EA5C3 D DAADBEEF 12345678 D 1 0 00000000 9
0 4 00000000 FFFFFFFF A DAADBEEF 12345678 D 1 1 FDFFFFFF 9
0 0 00000000 FFFFFFFF A DAADBEEF 12345678 D 1 0 00000000 9
0 5 00000000 FFFFFFFF A DAADBEEF 12345678 D 1 1 00000005 9
0 4 00000000 FFFFFFFF A DAADBEEF 12345678 D 1 1 FDFFFFFF 9
0 1 00000000 FFFFFFFF A 00000000 12345678 C 1 0 00000000 9
0 2 FFFFFFFF FFFFFFFF A 00000000 FBFFFFFF E 1 0 00000000 9
0 3 00000000 00000000 2 00000000 FBFFFFFF 2 1 0 00000000 9
0 5 00000000 00000000 2 00000000 FBFFFFFF 2 1 1 00000001 9
0 0 00000000 00000000 2 00000000 FBFFFFFF 2 1 0 00000000 9

// ==== sim_chip.f ====
hdl/chip_pwr_pkg.sv
hdl/chip_pad_pkg.sv
hdl/supply_por_gen.sv
hdl/pad_ring_map.sv
hdl/pad_ctrl_regs.sv
hdl/sim_chip_top.sv
verification/sim_chip_asserts.sv
verification/sim_chip_tb.sv

// ==== Bender.yml ====
package:
  name: sim_chip

sources:
  # packages first, then the blocks and the top level
  - hdl/chip_pwr_pkg.sv
  - hdl/chip_pad_pkg.sv
  - hdl/supply_por_gen.sv
  - hdl/pad_ring_map.sv
  - hdl/pad_ctrl_regs.sv
  - hdl/sim_chip_top.sv

  - target: test
    files:
      - verification/sim_chip_asserts.sv
      - verification/sim_chip_tb.sv

// ==== verification/sim_chip_tb.sv ====
/*
 * testbench for the simulation chip shell
 * replays the step trace against the DUT and compares every output
 */

`timescale 1ns/1ps

module sim_chip_tb import chip_pad_pkg::*; ();

  localparam string TraceFile = "verification/sim_chip_trace.txt";

  // trace step kinds
  localparam int KindStep = 0;
  localparam int KindWait = 1;

  logic     clk_aon;
  logic     rst_n;
  mio_vec_t gpio_in;
  logic     uart_rx;
  logic     spi_sck;
  logic     spi_csb;
  logic     spi_sdi;
  cfg_op_e  cfg_op;
  mio_vec_t cfg_wdata;

  mio_vec_t gpio_out;
  mio_vec_t gpio_en;
  logic     uart_tx;
  logic     uart_tx_en;
  logic     spi_sdo;
  logic     spi_sdo_en;
  mio_vec_t cfg_rdata;
  logic     cfg_rvalid;
  logic     pok;
  strap_t   dft_strap;
  strap_t   tap_strap;

  // one entry per trace step
  int         step_line[$];
  int         step_kind[$];
  int         step_op[$];
  mio_vec_t   step_wdata[$];
  mio_vec_t   step_gpio[$];
  logic [3:0] step_pins[$];
  mio_vec_t   exp_gpio[$];
  mio_vec_t   exp_gpio_en[$];
  logic [3:0] exp_pout[$];
  logic       exp_pok[$];
  logic       exp_rvalid[$];
  mio_vec_t   exp_rdata[$];
  logic [3:0] exp_strap[$];

  int cur_line;
  int cycle_cnt = 0;
  int cycle_limit = 0;
  bit trace_loaded = 1'b0;

  sim_chip_top DUT (
    .clk_aon      (clk_aon),
    .rst_n_i      (rst_n),
    .gpio_i       (gpio_in),
    .gpio_o       (gpio_out),
    .gpio_en_o    (gpio_en),
    .uart_rx_i    (uart_rx),
    .uart_tx_o    (uart_tx),
    .uart_tx_en_o (uart_tx_en),
    .spi_sck_i    (spi_sck),
    .spi_csb_i    (spi_csb),
    .spi_sdi_i    (spi_sdi),
    .spi_sdo_o    (spi_sdo),
    .spi_sdo_en_o (spi_sdo_en),
    .cfg_op_i     (cfg_op),
    .cfg_wdata_i  (cfg_wdata),
    .cfg_rdata_o  (cfg_rdata),
    .cfg_rvalid_o (cfg_rvalid),
    .pok_o        (pok),
    .dft_strap_o  (dft_strap),
    .tap_strap_o  (tap_strap)
  );

  initial clk_aon = 1'b0;
  always #5 clk_aon = ~clk_aon;

  //////////////////////////////////////////////////////////////////////
  // failure and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic check_word(input string what, input mio_vec_t got, input mio_vec_t exp);
    if (got !== exp) begin
      abort_run($sformatf("error @ %0t: trace line %0d, %s is %08h, expected %08h",
                          $time, cur_line, what, got, exp));
    end
  endtask

  task automatic check_strap(input string what, input strap_t got, input strap_t exp);
    if (got !== exp) begin
      abort_run($sformatf("error @ %0t: trace line %0d, %s is %b, expected %b",
                          $time, cur_line, what, got, exp));
    end
  endtask

  task automatic check_bit(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("error @ %0t: trace line %0d, %s is %b, expected %b",
                          $time, cur_line, what, got, exp));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // trace handling
  //////////////////////////////////////////////////////////////////////

  task automatic load_trace();
    int         fd;
    int         n_fields;
    int         line_no;
    string      line;
    int         kind;
    int         op;
    int         e_pok;
    int         e_rvalid;
    mio_vec_t   wdata;
    mio_vec_t   gpio;
    mio_vec_t   e_gpio;
    mio_vec_t   e_gpio_en;
    mio_vec_t   e_rdata;
    logic [3:0] pins;
    logic [3:0] e_pout;
    logic [3:0] e_strap;
    fd = $fopen(TraceFile, "r");
    line_no = 0;
    if (fd == 0) begin
      abort_run({"could not open the trace file ", TraceFile});
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      line_no++;
      // blank lines and comments
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      n_fields = $sscanf(line, "%d %d %h %h %h %h %h %h %d %d %h %h",
                         kind, op, wdata, gpio, pins, e_gpio, e_gpio_en, e_pout,
                         e_pok, e_rvalid, e_rdata, e_strap);
      if (n_fields != 12) begin
        abort_run($sformatf("trace line %0d is malformed, it has %0d of 12 fields",
                            line_no, n_fields));
      end
      if (kind != KindStep && kind != KindWait) begin
        abort_run($sformatf("trace line %0d has an unknown step kind %0d", line_no, kind));
      end
      step_line.push_back(line_no);
      step_kind.push_back(kind);
      step_op.push_back(op);
      step_wdata.push_back(wdata);
      step_gpio.push_back(gpio);
      step_pins.push_back(pins);
      exp_gpio.push_back(e_gpio);
      exp_gpio_en.push_back(e_gpio_en);
      exp_pout.push_back(e_pout);
      exp_pok.push_back(e_pok[0]);
      exp_rvalid.push_back(e_rvalid[0]);
      exp_rdata.push_back(e_rdata);
      exp_strap.push_back(e_strap);
    end
    $fclose(fd);
  endtask

  // pins nibble: uart rx, spi sck, spi csb, spi sdi from bit 0 up
  task automatic drive_step(input int idx);
    cur_line  = step_line[idx];
    cfg_op    = cfg_op_e'(step_op[idx]);
    cfg_wdata = step_wdata[idx];
    gpio_in   = step_gpio[idx];
    uart_rx   = step_pins[idx][0];
    spi_sck   = step_pins[idx][1];
    spi_csb   = step_pins[idx][2];
    spi_sdi   = step_pins[idx][3];
  endtask

  task automatic compare_step(input int idx);
    logic [3:0] pout;
    logic [3:0] strap;
    pout  = exp_pout[idx];
    strap = exp_strap[idx];
    check_bit("pok_o", pok, exp_pok[idx]);
    check_word("gpio_o", gpio_out, exp_gpio[idx]);
    check_word("gpio_en_o", gpio_en, exp_gpio_en[idx]);
    check_bit("uart_tx_o", uart_tx, pout[0]);
    check_bit("uart_tx_en_o", uart_tx_en, pout[1]);
    check_bit("spi_sdo_o", spi_sdo, pout[2]);
    check_bit("spi_sdo_en_o", spi_sdo_en, pout[3]);
    check_bit("cfg_rvalid_o", cfg_rvalid, exp_rvalid[idx]);
    // read data only means something next to its valid pulse
    if (exp_rvalid[idx]) begin
      check_word("cfg_rdata_o", cfg_rdata, exp_rdata[idx]);
    end
    check_strap("dft_strap_o", dft_strap, strap[1:0]);
    check_strap("tap_strap_o", tap_strap, strap[3:2]);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst_n     = 1'b0;
    gpio_in   = '0;
    uart_rx   = 1'b0;
    spi_sck   = 1'b0;
    spi_csb   = 1'b1;
    spi_sdi   = 1'b0;
    cfg_op    = CfgNop;
    cfg_wdata = '0;
    cur_line  = 0;

    load_trace();
    cycle_limit  = 4 * step_kind.size() + 50;
    trace_loaded = 1'b1;

    repeat (5) @(posedge clk_aon);
    #1;
    rst_n = 1'b1;

    foreach (step_kind[i]) begin
      drive_step(i);
      if (step_kind[i] == KindWait) begin
        // supply pattern sets the pace, wait for the power-ok level
        do begin
          @(posedge clk_aon);
          #1;
        end while (pok !== exp_pok[i]);
      end else begin
        @(posedge clk_aon);
        #1;
        compare_step(i);
      end
      if (DUT.u_asserts.any_fail) begin
        abort_run($sformatf("a bound assertion failed near trace line %0d", cur_line));
      end
    end

    if (DUT.u_asserts.any_fail) begin
      abort_run("a bound assertion failed during the run");
    end else begin
      $display("Done: no errors");
      $finish;
    end
  end

  // watchdog
  initial begin
    wait (trace_loaded);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk_aon);
      cycle_cnt++;
    end
    abort_run($sformatf("timeout: the trace did not finish within %0d cycles", cycle_limit));
  end

endmodule : sim_chip_tb

// ==== verification/sim_chip_asserts.sv ====
/*
 * bound checker for the chip shell: read valid timing,
 * enables held off before power-ok, straps frozen after power-ok
 */

`timescale 1ns/1ps

module sim_chip_asserts import chip_pad_pkg::*; (
  input logic     clk_aon,
  input logic     rst_n_i,
  input cfg_op_e  cfg_op_i,
  input logic     cfg_rvalid_i,
  input logic     pok_i,
  input mio_vec_t gpio_en_i,
  input logic     uart_tx_en_i,
  input logic     spi_sdo_en_i,
  input strap_t   dft_strap_i,
  input strap_t   tap_strap_i
);

  int unsigned rvalid_fails = 0;
  int unsigned gate_fails   = 0;
  int unsigned strap_fails  = 0;
  logic        pok_seen_q;
  logic        any_fail;

  assign any_fail = (rvalid_fails != 0) || (gate_fails != 0) || (strap_fails != 0);

  // straps latch on the same edge that first sees power-ok
  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pok_seen_q <= 1'b0;
    end else if (pok_i) begin
      pok_seen_q <= 1'b1;
    end
  end

  rvalid_after_read: assert property (@(posedge clk_aon) disable iff (!rst_n_i)
    cfg_rvalid_i |-> $past(cfg_op_i == CfgRdMio || cfg_op_i == CfgRdDio))
  else begin
    rvalid_fails++;
    $error("cfg_rvalid_o without a read opcode one cycle before");
  end

  no_enable_before_pok: assert property (@(posedge clk_aon) disable iff (!rst_n_i)
    !pok_i |-> (gpio_en_i == '0 && !uart_tx_en_i && !spi_sdo_en_i))
  else begin
    gate_fails++;
    $error("pad enable high while power-ok is low");
  end

  straps_frozen: assert property (@(posedge clk_aon) disable iff (!rst_n_i)
    (pok_seen_q && $past(pok_seen_q)) |-> ($stable(dft_strap_i) && $stable(tap_strap_i)))
  else begin
    strap_fails++;
    $error("strap outputs changed after power-ok");
  end

endmodule : sim_chip_asserts

bind sim_chip_top sim_chip_asserts u_asserts (
  .clk_aon      (clk_aon),
  .rst_n_i      (rst_n_i),
  .cfg_op_i     (cfg_op_i),
  .cfg_rvalid_i (cfg_rvalid_o),
  .pok_i        (pok_o),
  .gpio_en_i    (gpio_en_o),
  .uart_tx_en_i (uart_tx_en_o),
  .spi_sdo_en_i (spi_sdo_en_o),
  .dft_strap_i  (dft_strap_o),
  .tap_strap_i  (tap_strap_o)
);

// ==== hdl/sim_chip_top.sv ====
/*
 * simulation chip shell: always-on power sequencing,
 * pad ring map and pad control registers
 */

`timescale 1ns/1ps

module sim_chip_top import chip_pwr_pkg::*, chip_pad_pkg::*; #(
  parameter int unsigned pok_filter_cycles = PokFiltDefault
) (
  input  logic     clk_aon,
  input  logic     rst_n_i,

  // gpio
  input  mio_vec_t gpio_i,
  output mio_vec_t gpio_o,
  output mio_vec_t gpio_en_o,

  // uart
  input  logic     uart_rx_i,
  output logic     uart_tx_o,
  output logic     uart_tx_en_o,

  // spi
  input  logic     spi_sck_i,
  input  logic     spi_csb_i,
  input  logic     spi_sdi_i,
  output logic     spi_sdo_o,
  output logic     spi_sdo_en_o,

  // config port
  input  cfg_op_e  cfg_op_i,
  input  mio_vec_t cfg_wdata_i,
  output mio_vec_t cfg_rdata_o,
  output logic     cfg_rvalid_o,

  // status
  output logic     pok_o,
  output strap_t   dft_strap_o,
  output strap_t   tap_strap_o
);

  logic     pok;
  mio_vec_t mio_in;
  mio_vec_t mio_out;
  mio_vec_t mio_oe;
  dio_vec_t dio_in;
  dio_vec_t dio_out;
  dio_vec_t dio_oe;

  assign pok_o = pok;

  supply_por_gen #(
    .pok_filter_cycles(pok_filter_cycles)
  ) u_supply_por_gen (
    .clk_aon (clk_aon),
    .rst_n_i (rst_n_i),
    .pok_o   (pok)
  );

  pad_ring_map u_pad_ring_map (
    .pok_i        (pok),
    .gpio_i       (gpio_i),
    .uart_rx_i    (uart_rx_i),
    .spi_sck_i    (spi_sck_i),
    .spi_csb_i    (spi_csb_i),
    .spi_sdi_i    (spi_sdi_i),
    .mio_out_i    (mio_out),
    .mio_oe_i     (mio_oe),
    .dio_out_i    (dio_out),
    .dio_oe_i     (dio_oe),
    .mio_in_o     (mio_in),
    .dio_in_o     (dio_in),
    .gpio_o       (gpio_o),
    .gpio_en_o    (gpio_en_o),
    .uart_tx_o    (uart_tx_o),
    .uart_tx_en_o (uart_tx_en_o),
    .spi_sdo_o    (spi_sdo_o),
    .spi_sdo_en_o (spi_sdo_en_o)
  );

  pad_ctrl_regs u_pad_ctrl_regs (
    .clk_aon      (clk_aon),
    .rst_n_i      (rst_n_i),
    .pok_i        (pok),
    .cfg_op_i     (cfg_op_i),
    .cfg_wdata_i  (cfg_wdata_i),
    .cfg_rdata_o  (cfg_rdata_o),
    .cfg_rvalid_o (cfg_rvalid_o),
    .mio_in_i     (mio_in),
    .dio_in_i     (dio_in),
    .mio_out_o    (mio_out),
    .mio_oe_o     (mio_oe),
    .dio_out_o    (dio_out),
    .dio_oe_o     (dio_oe),
    .dft_strap_o  (dft_strap_o),
    .tap_strap_o  (tap_strap_o)
  );

endmodule : sim_chip_top

// ==== hdl/pad_ctrl_regs.sv ====
/*
 * pad control registers: pad drive and enables, input readback
 * over a strobe config port, strap capture at first power-ok
 */

`timescale 1ns/1ps

module pad_ctrl_regs import chip_pad_pkg::*; (
  input  logic     clk_aon,
  input  logic     rst_n_i,
  input  logic     pok_i,

  // config port
  input  cfg_op_e  cfg_op_i,
  input  mio_vec_t cfg_wdata_i,
  output mio_vec_t cfg_rdata_o,
  output logic     cfg_rvalid_o,

  // pad side
  input  mio_vec_t mio_in_i,
  input  dio_vec_t dio_in_i,
  output mio_vec_t mio_out_o,
  output mio_vec_t mio_oe_o,
  output dio_vec_t dio_out_o,
  output dio_vec_t dio_oe_o,

  // straps
  output strap_t   dft_strap_o,
  output strap_t   tap_strap_o
);

  mio_vec_t rd_mux;
  logic     rd_req;
  logic     strap_done_q;

  ////////////////////////////////////////////////////////////////////
  // writes
  ////////////////////////////////////////////////////////////////////

  // opcodes only count once power is ok
  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      mio_out_o <= '0;
      mio_oe_o  <= '0;
      dio_out_o <= '0;
      dio_oe_o  <= '0;
    end else if (pok_i) begin
      unique case (cfg_op_i)
        CfgWrOut: mio_out_o <= cfg_wdata_i;
        CfgWrOe:  mio_oe_o  <= cfg_wdata_i;
        CfgWrDio: begin
          // low nibble drives, next nibble enables
          dio_out_o <= cfg_wdata_i[NDioPads-1:0];
          dio_oe_o  <= cfg_wdata_i[2*NDioPads-1:NDioPads];
        end
        default: ;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////
  // reads
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    rd_req = 1'b0;
    rd_mux = mio_in_i;
    unique case (cfg_op_i)
      CfgRdMio: rd_req = 1'b1;
      CfgRdDio: begin
        rd_req = 1'b1;
        rd_mux = {{(NMioPads-NDioPads){1'b0}}, dio_in_i};
      end
      default: ;
    endcase
  end

  // one valid per read, back to back reads give back to back pulses
  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      cfg_rvalid_o <= 1'b0;
    end else begin
      cfg_rvalid_o <= rd_req & pok_i;
    end
  end

  always_ff @(posedge clk_aon) begin
    if (rd_req && pok_i) begin
      cfg_rdata_o <= rd_mux;
    end
  end

  ////////////////////////////////////////////////////////////////////
  // straps
  ////////////////////////////////////////////////////////////////////

  // captured once, on the first edge that sees power-ok
  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      strap_done_q <= 1'b0;
      dft_strap_o  <= '0;
      tap_strap_o  <= '0;
    end else if (pok_i && !strap_done_q) begin
      strap_done_q <= 1'b1;
      dft_strap_o  <= {mio_in_i[MioDftStrap1], mio_in_i[MioDftStrap0]};
      tap_strap_o  <= {mio_in_i[MioTapStrap1], mio_in_i[MioTapStrap0]};
    end
  end

endmodule : pad_ctrl_regs

// ==== hdl/pad_ring_map.sv ====
/*
 * pad ring map: chip pins onto the mio and dio pad vectors,
 * pad outputs back onto pins, all held off until power-ok
 */

`timescale 1ns/1ps

module pad_ring_map import chip_pad_pkg::*; (
  input  logic     pok_i,

  // pins in
  input  mio_vec_t gpio_i,
  input  logic     uart_rx_i,
  input  logic     spi_sck_i,
  input  logic     spi_csb_i,
  input  logic     spi_sdi_i,

  // pad drive from the register block
  input  mio_vec_t mio_out_i,
  input  mio_vec_t mio_oe_i,
  input  dio_vec_t dio_out_i,
  input  dio_vec_t dio_oe_i,

  // pad inputs to the register block
  output mio_vec_t mio_in_o,
  output dio_vec_t dio_in_o,

  // pins out
  output mio_vec_t gpio_o,
  output mio_vec_t gpio_en_o,
  output logic     uart_tx_o,
  output logic     uart_tx_en_o,
  output logic     spi_sdo_o,
  output logic     spi_sdo_en_o
);

  mio_vec_t mio_out_g;
  mio_vec_t mio_oe_g;

  ////////////////////////////////////////////////////////////////////
  // inbound
  ////////////////////////////////////////////////////////////////////

  always_comb begin
    mio_in_o = gpio_i;
    // uart rx overrides the gpio pin here
    mio_in_o[MioUartRx] = uart_rx_i;
  end

  always_comb begin
    dio_in_o = '0;
    dio_in_o[DioSpiSck] = spi_sck_i;
    dio_in_o[DioSpiCsb] = spi_csb_i;
    dio_in_o[DioSpiSd0] = spi_sdi_i;
  end

  ////////////////////////////////////////////////////////////////////
  // outbound
  ////////////////////////////////////////////////////////////////////

  // nothing reaches a pin before power-ok
  assign mio_out_g = mio_out_i & {NMioPads{pok_i}};
  assign mio_oe_g  = mio_oe_i & {NMioPads{pok_i}};

  // pad 26 belongs to uart tx, its gpio pin stays quiet
  always_comb begin
    gpio_o    = mio_out_g;
    gpio_en_o = mio_oe_g;
    gpio_o[MioUartTx]    = 1'b0;
    gpio_en_o[MioUartTx] = 1'b0;
  end

  assign uart_tx_o    = mio_out_g[MioUartTx];
  assign uart_tx_en_o = mio_oe_g[MioUartTx];

  // spi data out
  assign spi_sdo_o    = dio_out_i[DioSpiSd1] & pok_i;
  assign spi_sdo_en_o = dio_oe_i[DioSpiSd1] & pok_i;

endmodule : pad_ring_map

// ==== hdl/supply_por_gen.sv ====
/*
 * power-on sequencer: saturating counter builds a fake supply pattern
 * and a consecutive-sample filter turns it into power-ok
 */

`timescale 1ns/1ps

module supply_por_gen import chip_pwr_pkg::*; #(
  parameter int unsigned pok_filter_cycles = PokFiltDefault
) (
  input  logic clk_aon,
  input  logic rst_n_i,
  output logic pok_o
);

  localparam int unsigned FiltW = $clog2(pok_filter_cycles + 1);

  supp_cnt_t  supp_cnt_q;
  logic       supp_ok;
  pok_state_e pok_state_q;
  logic [FiltW-1:0] filt_cnt_q;

  ////////////////////////////////////////////////////////////////////
  // supply pattern
  ////////////////////////////////////////////////////////////////////

  // count up once per edge and hold at the top
  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      supp_cnt_q <= '0;
    end else if (supp_cnt_q != '1) begin
      supp_cnt_q <= supp_cnt_q + 1'b1;
    end
  end

  // low, high, low, then high for good
  assign supp_ok = (supp_cnt_q < SuppLowEnd)    ? 1'b0 :
                   (supp_cnt_q < SuppHighEnd)   ? 1'b1 :
                   (supp_cnt_q < SuppGlitchEnd) ? 1'b0 : 1'b1;

  ////////////////////////////////////////////////////////////////////
  // power-ok filter
  ////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_aon or negedge rst_n_i) begin
    if (!rst_n_i) begin
      pok_state_q <= PokOff;
      filt_cnt_q  <= '0;
    end else if (!supp_ok) begin
      // any low sample drops power-ok at once
      pok_state_q <= PokOff;
      filt_cnt_q  <= '0;
    end else begin
      unique case (pok_state_q)
        PokOff: begin
          pok_state_q <= PokFilter;
          filt_cnt_q  <= '0;
        end
        PokFilter: begin
          filt_cnt_q <= filt_cnt_q + 1'b1;
          if (filt_cnt_q == FiltW'(pok_filter_cycles - 1)) begin
            pok_state_q <= PokOn;
          end
        end
        default: pok_state_q <= PokOn;
      endcase
    end
  end

  assign pok_o = (pok_state_q == PokOn);

endmodule : supply_por_gen

// ==== hdl/chip_pad_pkg.sv ====
/*
 * pad ring definitions
 * pad counts, dedicated and strap pad positions, config opcodes
 */

package chip_pad_pkg;

  ////////////////////////////////////////////////////////////////////
  // pad vectors
  ////////////////////////////////////////////////////////////////////

  localparam int unsigned NMioPads = 32;
  localparam int unsigned NDioPads = 4;

  typedef logic [NMioPads-1:0] mio_vec_t;
  typedef logic [NDioPads-1:0] dio_vec_t;

  // dedicated pad positions
  typedef enum logic [1:0] {
    DioSpiSck = 2'd0,
    DioSpiCsb = 2'd1,
    DioSpiSd0 = 2'd2,
    DioSpiSd1 = 2'd3
  } dio_idx_e;

  // uart sits on fixed mio pads
  localparam int unsigned MioUartRx = 25;
  localparam int unsigned MioUartTx = 26;

  // strap pads, sampled at first power-ok
  localparam int unsigned MioDftStrap0 = 21;
  localparam int unsigned MioDftStrap1 = 22;
  localparam int unsigned MioTapStrap0 = 26;
  localparam int unsigned MioTapStrap1 = 16;

  typedef logic [1:0] strap_t;

  // config port opcodes
  typedef enum logic [2:0] {
    CfgNop,
    CfgWrOut,
    CfgWrOe,
    CfgWrDio,
    CfgRdMio,
    CfgRdDio
  } cfg_op_e;

endpackage : chip_pad_pkg

// ==== hdl/chip_pwr_pkg.sv ====
/*
 * always-on power domain definitions
 * supply counter type, fake supply pattern bounds and power-ok filter states
 */

package chip_pwr_pkg;

  ////////////////////////////////////////////////////////////////////
  // supply counter
  ////////////////////////////////////////////////////////////////////

  // counter saturates at all ones
  localparam int unsigned SuppCntW = 4;

  typedef logic [SuppCntW-1:0] supp_cnt_t;

  // pattern is low, high, low, high split at these counter values
  localparam supp_cnt_t SuppLowEnd    = 4'd4;
  localparam supp_cnt_t SuppHighEnd   = 4'd8;
  localparam supp_cnt_t SuppGlitchEnd = 4'd12;

  ////////////////////////////////////////////////////////////////////
  // power-ok filter
  ////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    PokOff,
    PokFilter,
    PokOn
  } pok_state_e;

  // short enough to let the glitch window through once
  localparam int unsigned PokFiltDefault = 3;

endpackage : chip_pwr_pkg
